// ==== Makefile ====
# Verilator flow for the peripheral wrapper and its testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== byte_periph_bank.sv ====
`timescale 1ns/100ps
/* Byte slot bank
   Edge counter with clear-on-read in slot 0, four-byte register file in slot 1 */
module byte_periph_bank
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    periph_bus_if.periph      bus,
    input  logic [PIN_W-1:0]  i_ui_in,
    output logic [DATA_W-1:0] o_rdata,
    output logic              o_ready,
    output logic [PIN_W-1:0]  o_pins [NUM_SLOTS]
);

    logic [SLOT_W-1:0]     slot;
    logic [BYTE_OFS_W-1:0] ofs;
    logic                  wr;
    logic                  rd;
    logic [2:0]            edge_pin;
    logic [7:0]            edge_cnt;
    logic [PIN_W-1:0]      ui_prev;
    logic                  edge_seen;
    logic                  edge_clr;
    logic                  reg_hit;
    logic [7:0]            regs [BYTEREG_N];
    logic [7:0]            rbyte;

    assign slot = bus.addr.byte_v.slot;
    assign ofs  = bus.addr.byte_v.ofs;
    assign wr   = (bus.write_n != SIZE_NONE) && bus.addr.byte_v.bank;
    assign rd   = (bus.read_n != SIZE_NONE) && bus.addr.byte_v.bank;

    always_ff @(posedge clk) begin
        ui_prev <= i_ui_in;
    end

    assign edge_seen = i_ui_in[edge_pin] && !ui_prev[edge_pin];
    assign edge_clr  = rd && (slot == SLOT_EDGE) && (ofs == EDGE_CNT_OFS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            edge_cnt <= '0;
            edge_pin <= '0;
        end else begin
            // The read returns the old count, this cycle's edge starts the new one
            if (edge_clr) begin
                edge_cnt <= {7'b0, edge_seen};
            end else if (edge_seen && (edge_cnt != 8'hff)) begin
                edge_cnt <= edge_cnt + 1'b1;
            end
            if (wr && (slot == SLOT_EDGE) && (ofs == EDGE_PIN_OFS)) begin
                edge_pin <= bus.wdata[2:0];
            end
        end
    end

    assign reg_hit = (ofs[BYTE_OFS_W-1:2] == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BYTEREG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr && (slot == SLOT_BYTEREG) && reg_hit) begin
            regs[ofs[1:0]] <= bus.wdata[7:0];
        end
    end

    always_comb begin
        rbyte = '0;
        if (slot == SLOT_EDGE) begin
            if (ofs == EDGE_CNT_OFS) begin
                rbyte = edge_cnt;
            end else if (ofs == EDGE_PIN_OFS) begin
                rbyte = {5'b0, edge_pin};
            end
        end else if ((slot == SLOT_BYTEREG) && reg_hit) begin
            rbyte = regs[ofs[1:0]];
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            o_pins[s] = '0;
        end
        o_pins[SLOT_EDGE]    = edge_cnt;
        o_pins[SLOT_BYTEREG] = regs[0];
    end

    assign o_rdata = DATA_W'(rbyte);
    assign o_ready = 1'b1;

endmodule

// ==== flist.f ====
periph_pkg.sv
periph_bus_if.sv
periph_merge.sv
full_periph_bank.sv
byte_periph_bank.sv
periph_top.sv
tb_periph_top.sv

// ==== full_periph_bank.sv ====
`timescale 1ns/100ps
/* Full-width slot bank
   GPIO with per-pin function select in slot 1, compare timer in slot 2 */
module full_periph_bank
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    periph_bus_if.periph          bus,
    input  logic [PIN_W-1:0]      i_ui_in,
    output logic [DATA_W-1:0]     o_rdata,
    output logic                  o_ready,
    output logic [PIN_W-1:0]      o_pins [NUM_SLOTS],
    output logic [FUNC_SEL_W-1:0] o_func_sel [PIN_W],
    output logic                  o_timer_irq
);

    logic [SLOT_W-1:0]     slot;
    logic [FULL_OFS_W-1:0] ofs;
    logic                  wr;
    logic                  gpio_wr;
    logic                  tmr_wr;
    logic                  sel_hit;
    logic [2:0]            sel_idx;
    logic [PIN_W-1:0]      gpio_out;
    logic [FUNC_SEL_W-1:0] func_sel [PIN_W];
    logic [DATA_W-1:0]     tmr_count;
    logic [DATA_W-1:0]     tmr_next;
    logic [DATA_W-1:0]     tmr_cmp;
    logic                  tmr_irq;
    logic                  cnt_load;

    assign slot    = bus.addr.full_v.slot;
    assign ofs     = bus.addr.full_v.ofs;
    assign wr      = (bus.write_n != SIZE_NONE) && !bus.addr.full_v.bank;
    assign gpio_wr = wr && (slot == SLOT_GPIO);
    assign tmr_wr  = wr && (slot == SLOT_TIMER);

    // Word-aligned offsets 32..60, one per output pin
    assign sel_hit = ({ofs[5], 3'b000, ofs[1:0]} == GPIO_SEL_BASE);
    assign sel_idx = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < PIN_W; i++) begin
                func_sel[i] <= {1'b0, SLOT_GPIO};
            end
        end else if (gpio_wr) begin
            if (ofs == GPIO_OUT_OFS) begin
                gpio_out <= bus.wdata[PIN_W-1:0];
            end
            if (sel_hit) begin
                func_sel[sel_idx] <= bus.wdata[FUNC_SEL_W-1:0];
            end
        end
    end

    assign cnt_load = tmr_wr && (ofs == TMR_COUNT_OFS);
    assign tmr_next = tmr_count + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tmr_count <= '0;
            tmr_cmp   <= '0;
            tmr_irq   <= 1'b0;
        end else begin
            if (cnt_load) begin
                tmr_count <= bus.wdata;
            end else begin
                tmr_count <= tmr_next;
            end
            if (tmr_wr && (ofs == TMR_CMP_OFS)) begin
                tmr_cmp <= bus.wdata;
            end
            // Flag rises as the counter steps onto the compare value
            // A match wins over a clear in the same cycle
            if (!cnt_load && (tmr_next == tmr_cmp)) begin
                tmr_irq <= 1'b1;
            end else if (tmr_wr && (ofs == TMR_CLR_OFS)) begin
                tmr_irq <= 1'b0;
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        case (slot)
            SLOT_GPIO: begin
                if (ofs == GPIO_OUT_OFS) begin
                    o_rdata = DATA_W'(gpio_out);
                end else if (ofs == GPIO_IN_OFS) begin
                    o_rdata = DATA_W'(i_ui_in);
                end else if (sel_hit) begin
                    o_rdata = DATA_W'(func_sel[sel_idx]);
                end
            end
            SLOT_TIMER: begin
                if (ofs == TMR_COUNT_OFS) begin
                    o_rdata = tmr_count;
                end else if (ofs == TMR_CMP_OFS) begin
                    o_rdata = tmr_cmp;
                end else if (ofs == TMR_CLR_OFS) begin
                    o_rdata = DATA_W'(tmr_irq);
                end
            end
            default: o_rdata = '0;
        endcase
    end

    // Empty slots leave their pins low
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            o_pins[s] = '0;
        end
        o_pins[SLOT_GPIO]  = gpio_out;
        o_pins[SLOT_TIMER] = {PIN_W{tmr_irq}};
    end

    // Every slot answers in the same cycle
    assign o_ready     = 1'b1;
    assign o_func_sel  = func_sel;
    assign o_timer_irq = tmr_irq;

endmodule

// ==== periph_bus_if.sv ====
`timescale 1ns/100ps
/* Peripheral bus
   Decoded core access fanned out from the read-return block to both banks */
interface periph_bus_if
    import periph_pkg::*;
();

    periph_addr_u      addr;
    logic [DATA_W-1:0] wdata;
    size_t             write_n;
    // Masked to idle while a read result is held
    size_t             read_n;

    modport host (
        output addr,
        output wdata,
        output write_n,
        output read_n
    );

    modport periph (
        input addr,
        input wdata,
        input write_n,
        input read_n
    );

endinterface

// ==== periph_merge.sv ====
`timescale 1ns/100ps
/* Read-return and pin routing
   Registers the bank read word until completion, masks repeat reads, routes pins */
module periph_merge
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [ADDR_W-1:0]     i_addr,
    input  logic [DATA_W-1:0]     i_data_in,
    input  size_t                 i_data_write_n,
    input  size_t                 i_data_read_n,
    input  logic                  i_data_read_complete,
    periph_bus_if.host            bus,
    input  logic [DATA_W-1:0]     i_full_rdata,
    input  logic                  i_full_ready,
    input  logic [DATA_W-1:0]     i_byte_rdata,
    input  logic                  i_byte_ready,
    input  logic [PIN_W-1:0]      i_full_pins [NUM_SLOTS],
    input  logic [PIN_W-1:0]      i_byte_pins [NUM_SLOTS],
    input  logic [FUNC_SEL_W-1:0] i_func_sel [PIN_W],
    output logic [DATA_W-1:0]     o_data_out,
    output logic                  o_data_ready,
    output logic [PIN_W-1:0]      o_uo_out
);

    logic              read_req;
    logic              byte_sel;
    logic [DATA_W-1:0] slot_rdata;
    logic              slot_ready;
    logic              capture;
    logic              data_hold;
    logic              data_ready_r;
    logic [DATA_W-1:0] data_out_r;

    assign read_req   = (i_data_read_n != SIZE_NONE);
    assign byte_sel   = i_addr[ADDR_W-1];
    assign slot_rdata = byte_sel ? i_byte_rdata : i_full_rdata;
    assign slot_ready = byte_sel ? i_byte_ready : i_full_ready;
    assign capture    = read_req && slot_ready && !data_hold;

    assign bus.addr    = i_addr;
    assign bus.wdata   = i_data_in;
    assign bus.write_n = i_data_write_n;
    // Banks see no read once the result is registered
    assign bus.read_n  = i_data_read_n | {2{data_ready_r}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold    <= 1'b0;
            data_ready_r <= 1'b0;
        end else begin
            if (capture) begin
                data_hold <= 1'b1;
            end else if (i_data_read_complete) begin
                data_hold <= 1'b0;
            end
            data_ready_r <= read_req && slot_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_out_r <= slot_rdata;
        end
    end

    assign o_data_out   = data_out_r;
    // Writes complete in the cycle they are issued
    assign o_data_ready = data_ready_r || (i_data_write_n != SIZE_NONE);

    // Top select bit picks the bank, low bits the slot
    for (genvar p = 0; p < PIN_W; p++) begin : g_pin
        logic [SLOT_W-1:0] src;

        assign src         = i_func_sel[p][SLOT_W-1:0];
        assign o_uo_out[p] = i_func_sel[p][FUNC_SEL_W-1] ? i_byte_pins[src][p]
                                                         : i_full_pins[src][p];
    end

endmodule

// ==== periph_pkg.sv ====
/* Peripheral bus package
   Address map, slot numbers, register offsets, size codes and the address word views */
package periph_pkg;

    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int PIN_W      = 8;
    localparam int SLOT_W     = 4;
    localparam int FULL_OFS_W = 6;
    localparam int BYTE_OFS_W = 4;
    localparam int FUNC_SEL_W = 5;
    localparam int NUM_SLOTS  = 1 << SLOT_W;
    localparam int BYTEREG_N  = 4;

    // 11 is idle, 00/01/10 are 8/16/32 bit accesses
    typedef logic [1:0] size_t;
    localparam size_t SIZE_NONE = 2'b11;

    // Slot numbers
    localparam logic [SLOT_W-1:0] SLOT_GPIO    = 4'd1;
    localparam logic [SLOT_W-1:0] SLOT_TIMER   = 4'd2;
    localparam logic [SLOT_W-1:0] SLOT_EDGE    = 4'd0;
    localparam logic [SLOT_W-1:0] SLOT_BYTEREG = 4'd1;

    // GPIO offsets with the select registers at 32..60 in steps of 4
    localparam logic [FULL_OFS_W-1:0] GPIO_OUT_OFS  = 6'd0;
    localparam logic [FULL_OFS_W-1:0] GPIO_IN_OFS   = 6'd4;
    localparam logic [FULL_OFS_W-1:0] GPIO_SEL_BASE = 6'd32;

    // Timer offsets
    localparam logic [FULL_OFS_W-1:0] TMR_COUNT_OFS = 6'd0;
    localparam logic [FULL_OFS_W-1:0] TMR_CMP_OFS   = 6'd4;
    localparam logic [FULL_OFS_W-1:0] TMR_CLR_OFS   = 6'd8;

    // Edge counter offsets
    localparam logic [BYTE_OFS_W-1:0] EDGE_CNT_OFS = 4'd0;
    localparam logic [BYTE_OFS_W-1:0] EDGE_PIN_OFS = 4'd1;

    // One address word, decoded per bank
    typedef union packed {
        struct packed {
            logic                  bank;
            logic [SLOT_W-1:0]     slot;
            logic [FULL_OFS_W-1:0] ofs;
        } full_v;
        struct packed {
            logic                  bank;
            logic [1:0]            unused;
            logic [SLOT_W-1:0]     slot;
            logic [BYTE_OFS_W-1:0] ofs;
        } byte_v;
    } periph_addr_u;

endpackage

// ==== periph_top.sv ====
`timescale 1ns/100ps
/* Peripheral wrapper top
   Read-return block and the full-width and byte slot banks */
module periph_top
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [PIN_W-1:0]  i_ui_in,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data_in,
    input  size_t             i_data_write_n,
    input  size_t             i_data_read_n,
    input  logic              i_data_read_complete,
    output logic [PIN_W-1:0]  o_uo_out,
    output logic [DATA_W-1:0] o_data_out,
    output logic              o_data_ready,
    output logic              o_timer_irq
);

    logic [DATA_W-1:0]     full_rdata;
    logic                  full_ready;
    logic [PIN_W-1:0]      full_pins [NUM_SLOTS];
    logic [FUNC_SEL_W-1:0] func_sel [PIN_W];
    logic [DATA_W-1:0]     byte_rdata;
    logic                  byte_ready;
    logic [PIN_W-1:0]      byte_pins [NUM_SLOTS];

    periph_bus_if bus ();

    periph_merge u_merge (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data_in            (i_data_in),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .bus                  (bus.host),
        .i_full_rdata         (full_rdata),
        .i_full_ready         (full_ready),
        .i_byte_rdata         (byte_rdata),
        .i_byte_ready         (byte_ready),
        .i_full_pins          (full_pins),
        .i_byte_pins          (byte_pins),
        .i_func_sel           (func_sel),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out)
    );

    full_periph_bank u_full (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus.periph),
        .i_ui_in     (i_ui_in),
        .o_rdata     (full_rdata),
        .o_ready     (full_ready),
        .o_pins      (full_pins),
        .o_func_sel  (func_sel),
        .o_timer_irq (o_timer_irq)
    );

    byte_periph_bank u_byte (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus.periph),
        .i_ui_in (i_ui_in),
        .o_rdata (byte_rdata),
        .o_ready (byte_ready),
        .o_pins  (byte_pins)
    );

endmodule

// ==== tb_periph_top.sv ====
`timescale 1ns/100ps
/* Testbench for the peripheral wrapper
   Random bus traffic checked against a cycle model of registers, timer, edge count and pins */
module tb_periph_top
    import periph_pkg::*;
();

    localparam int     CLK_PERIOD = 100;
    localparam int     SETTLE     = 10;
    localparam int     MAX_HOLD   = 6;
    localparam int     LONG_HOLD  = 24;
    localparam int     NUM_TXN    = 600;
    localparam int     TXN_CYCLES = MAX_HOLD + 4;
    localparam longint TIMEOUT    = longint'(NUM_TXN * TXN_CYCLES + 1000) * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    logic [PIN_W-1:0]  i_ui_in;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] i_data_in;
    size_t             i_data_write_n;
    size_t             i_data_read_n;
    logic              i_data_read_complete;
    logic [PIN_W-1:0]  o_uo_out;
    logic [DATA_W-1:0] o_data_out;
    logic              o_data_ready;
    logic              o_timer_irq;

    logic [31:0]       seed;
    int                errors = 0;
    int                mon_errors = 0;
    int                txns = 0;
    logic              pin_noise;
    logic              read_start;
    logic              model_valid = 1'b0;
    logic [DATA_W-1:0] exp_rdata;

    // Reference model state
    logic [7:0]        m_gpio;
    logic [4:0]        m_sel [PIN_W];
    logic [31:0]       m_count;
    logic [31:0]       m_cmp;
    logic              m_irq;
    logic [7:0]        m_edge_cnt;
    logic [2:0]        m_edge_pin;
    logic [7:0]        m_ui_prev;
    logic [7:0]        m_regs [4];

    periph_top uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .i_addr               (i_addr),
        .i_data_in            (i_data_in),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_uo_out             (o_uo_out),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_timer_irq          (o_timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic int hold_rand();
        return int'(rand32() % (MAX_HOLD + 1));
    endfunction

    function automatic logic [ADDR_W-1:0] full_addr(input logic [3:0] slot, input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [ADDR_W-1:0] byte_addr(input logic [3:0] slot, input logic [3:0] ofs);
        return {1'b1, 2'b00, slot, ofs};
    endfunction

    // Read word the register map predicts for the current model state
    function automatic logic [DATA_W-1:0] expect_read(input logic [ADDR_W-1:0] addr);
        logic [3:0]  fslot;
        logic [5:0]  fofs;
        logic [3:0]  bslot;
        logic [3:0]  bofs;
        logic [31:0] v;
        fslot = addr[9:6];
        fofs  = addr[5:0];
        bslot = addr[7:4];
        bofs  = addr[3:0];
        v     = '0;
        if (!addr[10]) begin
            if (fslot == SLOT_GPIO) begin
                if (fofs == GPIO_OUT_OFS) v = {24'b0, m_gpio};
                else if (fofs == GPIO_IN_OFS) v = {24'b0, i_ui_in};
                else if (fofs[5] && fofs[1:0] == 2'b00) v = {27'b0, m_sel[fofs[4:2]]};
            end else if (fslot == SLOT_TIMER) begin
                if (fofs == TMR_COUNT_OFS) v = m_count;
                else if (fofs == TMR_CMP_OFS) v = m_cmp;
                else if (fofs == TMR_CLR_OFS) v = {31'b0, m_irq};
            end
        end else begin
            if (bslot == SLOT_EDGE) begin
                if (bofs == EDGE_CNT_OFS) v = {24'b0, m_edge_cnt};
                else if (bofs == EDGE_PIN_OFS) v = {29'b0, m_edge_pin};
            end else if (bslot == SLOT_BYTEREG && bofs[3:2] == 2'b00) begin
                v = {24'b0, m_regs[bofs[1:0]]};
            end
        end
        return v;
    endfunction

    // Pin routing by function select
    // The top select bit picks the byte bank
    function automatic logic [PIN_W-1:0] expect_pins();
        logic [PIN_W-1:0] pins;
        logic [PIN_W-1:0] src;
        logic [3:0]       slot;
        pins = '0;
        for (int p = 0; p < PIN_W; p++) begin
            slot = m_sel[p][3:0];
            src  = '0;
            if (m_sel[p][4]) begin
                if (slot == SLOT_EDGE) src = m_edge_cnt;
                else if (slot == SLOT_BYTEREG) src = m_regs[0];
            end else begin
                if (slot == SLOT_GPIO) src = m_gpio;
                else if (slot == SLOT_TIMER) src = {PIN_W{m_irq}};
            end
            pins[p] = src[p];
        end
        return pins;
    endfunction

    // Cycle model of the DUT state at each rising edge
    always @(posedge clk) begin : model
        logic        wr_full;
        logic        wr_byte;
        logic        edge_hit;
        logic        cnt_load;
        logic [31:0] cnt_new;
        logic [3:0]  fslot;
        logic [5:0]  fofs;
        logic [3:0]  bslot;
        logic [3:0]  bofs;
        model_valid = 1'b1;
        fslot = i_addr[9:6];
        fofs  = i_addr[5:0];
        bslot = i_addr[7:4];
        bofs  = i_addr[3:0];
        if (!rst_n) begin
            m_gpio     = '0;
            m_count    = '0;
            m_cmp      = '0;
            m_irq      = 1'b0;
            m_edge_cnt = '0;
            m_edge_pin = '0;
            for (int i = 0; i < PIN_W; i++) m_sel[i] = {1'b0, SLOT_GPIO};
            for (int i = 0; i < 4; i++) m_regs[i] = '0;
        end else begin
            wr_full  = (i_data_write_n != SIZE_NONE) && !i_addr[10];
            wr_byte  = (i_data_write_n != SIZE_NONE) && i_addr[10];
            edge_hit = i_ui_in[m_edge_pin] && !m_ui_prev[m_edge_pin];
            // Returned word reflects the state before this edge
            if (read_start) exp_rdata = expect_read(i_addr);
            if (read_start && i_addr[10] && bslot == SLOT_EDGE && bofs == EDGE_CNT_OFS) begin
                m_edge_cnt = {7'b0, edge_hit};
            end else if (edge_hit && m_edge_cnt != 8'hff) begin
                m_edge_cnt = m_edge_cnt + 8'd1;
            end
            if (wr_byte && bslot == SLOT_EDGE && bofs == EDGE_PIN_OFS) m_edge_pin = i_data_in[2:0];
            if (wr_byte && bslot == SLOT_BYTEREG && bofs[3:2] == 2'b00) begin
                m_regs[bofs[1:0]] = i_data_in[7:0];
            end
            if (wr_full && fslot == SLOT_GPIO) begin
                if (fofs == GPIO_OUT_OFS) m_gpio = i_data_in[7:0];
                if (fofs[5] && fofs[1:0] == 2'b00) m_sel[fofs[4:2]] = i_data_in[4:0];
            end
            cnt_load = wr_full && fslot == SLOT_TIMER && fofs == TMR_COUNT_OFS;
            cnt_new  = cnt_load ? i_data_in : m_count + 32'd1;
            if (!cnt_load && cnt_new == m_cmp) begin
                m_irq = 1'b1;
            end else if (wr_full && fslot == SLOT_TIMER && fofs == TMR_CLR_OFS) begin
                m_irq = 1'b0;
            end
            m_count = cnt_new;
            if (wr_full && fslot == SLOT_TIMER && fofs == TMR_CMP_OFS) m_cmp = i_data_in;
        end
        m_ui_prev = i_ui_in;
    end

    // Pins and interrupt are compared every cycle
    always @(negedge clk) begin
        if (model_valid) begin
            assert (o_uo_out === expect_pins()) else begin
                mon_errors++;
                $display("Mismatch o_uo_out: got %h, expected %h", o_uo_out, expect_pins());
            end
            assert (o_timer_irq === m_irq) else begin
                mon_errors++;
                $display("Mismatch o_timer_irq: got %h, expected %h", o_timer_irq, m_irq);
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string text);
        assert (cond === 1'b1) else begin
            errors++;
            $display("Error: %s", text);
        end
    endtask

    task automatic tick();
        logic [31:0] r;
        @(negedge clk);
        if (pin_noise) begin
            r = rand32();
            i_ui_in = r[PIN_W-1:0];
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] r;
        tick();
        r = rand32();
        i_addr = addr;
        i_data_in = data;
        i_data_write_n = size_t'(r % 3);
        #SETTLE;
        check_true(o_data_ready, "o_data_ready low during a write");
        tick();
        i_data_write_n = SIZE_NONE;
        txns++;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, input int hold,
                            output logic [31:0] data);
        logic [31:0] r;
        logic [31:0] held;
        tick();
        r = rand32();
        i_addr = addr;
        i_data_read_n = size_t'(r % 3);
        read_start = 1'b1;
        #SETTLE;
        check_true(!o_data_ready, "o_data_ready high before the read was registered");
        tick();
        read_start = 1'b0;
        check_true(o_data_ready, "o_data_ready not high one cycle after the read began");
        check_value("o_data_out", o_data_out, exp_rdata);
        held = o_data_out;
        for (int i = 0; i < hold; i++) begin
            tick();
            check_true(o_data_ready, "o_data_ready dropped while the read was held");
            check_value("o_data_out", o_data_out, held);
        end
        i_data_read_n = SIZE_NONE;
        i_data_read_complete = 1'b1;
        tick();
        i_data_read_complete = 1'b0;
        #SETTLE;
        check_true(!o_data_ready, "o_data_ready still high after the read completed");
        data = held;
        txns++;
    endtask

    function automatic logic [ADDR_W-1:0] pick_addr(input logic [31:0] r);
        logic [3:0] slot;
        logic [5:0] fofs;
        logic [3:0] bofs;
        if (!r[0]) begin
            case (r[2:1])
                2'd0:    slot = SLOT_GPIO;
                2'd1:    slot = SLOT_TIMER;
                default: slot = r[6:3];
            endcase
            case (r[9:7])
                3'd0:             fofs = GPIO_OUT_OFS;
                3'd1:             fofs = GPIO_IN_OFS;
                3'd2:             fofs = TMR_CLR_OFS;
                3'd3, 3'd4, 3'd5: fofs = {1'b1, r[12:10], 2'b00};
                default:          fofs = r[15:10];
            endcase
            return full_addr(slot, fofs);
        end
        case (r[2:1])
            2'd0:    slot = SLOT_EDGE;
            2'd1:    slot = SLOT_BYTEREG;
            default: slot = r[6:3];
        endcase
        case (r[8:7])
            2'd0:    bofs = EDGE_CNT_OFS;
            2'd1:    bofs = EDGE_PIN_OFS;
            2'd2:    bofs = {2'b00, r[11:10]};
            default: bofs = r[13:10];
        endcase
        return byte_addr(slot, bofs);
    endfunction

    task automatic gpio_test();
        logic [31:0] r;
        logic [31:0] d;
        for (int i = 0; i < 16; i++) begin
            r = rand32();
            bus_write(full_addr(SLOT_GPIO, GPIO_OUT_OFS), r);
            bus_read(full_addr(SLOT_GPIO, GPIO_OUT_OFS), hold_rand(), d);
            check_value("o_data_out", d, {24'b0, r[7:0]});
        end
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            tick();
            i_ui_in = r[PIN_W-1:0];
            bus_read(full_addr(SLOT_GPIO, GPIO_IN_OFS), hold_rand(), d);
            check_value("o_data_out", d, {24'b0, r[7:0]});
        end
    endtask

    // Compare value set ahead of a loaded counter
    task automatic timer_test();
        int waited;
        bus_write(full_addr(SLOT_TIMER, TMR_COUNT_OFS), 32'h0000_1000);
        bus_write(full_addr(SLOT_TIMER, TMR_CMP_OFS), 32'h0000_1020);
        check_true(!o_timer_irq, "timer interrupt set before the compare match");
        waited = 0;
        while (!o_timer_irq && waited < 100) begin
            tick();
            waited++;
        end
        check_true(o_timer_irq, "timer interrupt never set on the compare match");
    endtask

    // Each pin steps through GPIO, byte register, timer flag and a random select
    task automatic routing_test();
        logic [31:0] r;
        logic [4:0]  sel;
        for (int round = 0; round < 6; round++) begin
            bus_write(full_addr(SLOT_GPIO, GPIO_OUT_OFS), rand32());
            bus_write(byte_addr(SLOT_BYTEREG, 4'd0), rand32());
            for (int p = 0; p < PIN_W; p++) begin
                r = rand32();
                case ((round + p) % 4)
                    0:       sel = {1'b0, SLOT_GPIO};
                    1:       sel = {1'b1, SLOT_BYTEREG};
                    2:       sel = {1'b0, SLOT_TIMER};
                    default: sel = r[4:0];
                endcase
                bus_write(full_addr(SLOT_GPIO, {1'b1, 3'(p), 2'b00}), {27'b0, sel});
            end
            repeat (3) tick();
        end
        // Unpopulated full slot 3 on every pin
        for (int p = 0; p < PIN_W; p++) begin
            bus_write(full_addr(SLOT_GPIO, {1'b1, 3'(p), 2'b00}), 32'd3);
        end
        check_value("o_uo_out", {24'b0, o_uo_out}, 32'd0);
    endtask

    task automatic read_test();
        logic [31:0] r;
        logic [31:0] d;
        for (int i = 0; i < 60; i++) begin
            r = rand32();
            if (i % 3 == 0) begin
                if (r[31]) bus_read(byte_addr(4'd2 + 4'(r % 14), r[7:4]), hold_rand(), d);
                else bus_read(full_addr(4'd3 + 4'(r % 13), r[9:4]), hold_rand(), d);
                check_value("o_data_out", d, 32'd0);
            end else begin
                bus_read(pick_addr(r), hold_rand(), d);
            end
        end
    endtask

    task automatic edge_test();
        logic [31:0] d;
        pin_noise = 1'b1;
        for (int round = 0; round < 4; round++) begin
            bus_write(byte_addr(SLOT_EDGE, EDGE_PIN_OFS), rand32());
            bus_read(byte_addr(SLOT_EDGE, EDGE_CNT_OFS), 0, d);
            repeat (30) tick();
            bus_read(byte_addr(SLOT_EDGE, EDGE_CNT_OFS), LONG_HOLD, d);
            bus_read(byte_addr(SLOT_EDGE, EDGE_CNT_OFS), 0, d);
        end
    endtask

    task automatic mixed_test();
        logic [31:0] r;
        logic [31:0] d;
        for (int i = 0; i < 300; i++) begin
            r = rand32();
            if (r[16]) bus_write(pick_addr(r), rand32());
            else bus_read(pick_addr(r), hold_rand(), d);
        end
    endtask

    initial begin
        logic [31:0] d;
        seed = 32'h2b994482;
        rst_n = 1'b0;
        i_ui_in = '0;
        i_addr = '0;
        i_data_in = '0;
        i_data_write_n = SIZE_NONE;
        i_data_read_n = SIZE_NONE;
        i_data_read_complete = 1'b0;
        pin_noise = 1'b0;
        read_start = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_value("o_uo_out", {24'b0, o_uo_out}, 32'd0);
        check_value("o_data_ready", {31'b0, o_data_ready}, 32'd0);
        check_value("o_timer_irq", {31'b0, o_timer_irq}, 32'd0);

        gpio_test();
        timer_test();
        routing_test();
        bus_read(full_addr(SLOT_TIMER, TMR_CLR_OFS), hold_rand(), d);
        check_value("o_data_out", d, 32'd1);
        bus_write(full_addr(SLOT_TIMER, TMR_CLR_OFS), 32'd0);
        check_true(!o_timer_irq, "timer interrupt not cleared by the offset 8 write");
        read_test();
        edge_test();
        mixed_test();
        repeat (2) tick();

        $display("Transactions: %0d, bus errors: %0d, pin errors: %0d",
                 txns, errors, mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
